//--- include/busDecode_settings.svh
////////////////////////////////////////////////////////////
// Widths and fixed codes of the Zorro 2 bus decoder
// Included by the package, the decode blocks and the testbench
////////////////////////////////////////////////////////////

`ifndef BUSDECODE_SETTINGS_SVH
`define BUSDECODE_SETTINGS_SVH

// Decoded address bits 31 down to 12
`define ADDR_HI_W 20

// Address bits 23:16 of the fixed Z2 spaces
`define SPACE_CIA        8'hBF
`define SPACE_REGS       8'hDF
`define SPACE_RTC        8'hDC
`define SPACE_AUTOCONFIG 8'hE8

// Autoconfig register that takes the base, address bits 15:12
`define AC_REG_BASE 4'h4

// Address bits 27:20 inside the Prometheus window
`define PRO_CONF0 8'hFC
`define PRO_CONF1 8'hFD
`define PRO_IO    8'hFE

`endif

//--- source/busDecodePkg.sv
////////////////////////////////////////////////////////////
// Shared types of the bus decoder
// Imported by every module of the design
////////////////////////////////////////////////////////////

`include "busDecode_settings.svh"

package busDecodePkg;

  // Address bits 31:12 as seen by the decoder
  typedef logic [`ADDR_HI_W-1:0] addrHigh_t;

  // 68040 transfer type and modifier
  typedef logic [1:0] transferType_t;
  typedef logic [2:0] transferMod_t;

  // Upper byte of the write data, D31:24
  typedef logic [7:0] busByte_t;

  // Base addresses learned through autoconfig
  typedef logic [6:0] ideBase_t;     // A23:17, 128 KB window
  typedef logic [7:0] bridgeBase_t;  // A23:16, 64 KB window
  typedef logic [3:0] proBase_t;     // A31:28, 256 MB window

  typedef logic [1:0] flashBank_t;

  // 0 config type 0, 1 config type 1, 2 memory, 3 I/O
  typedef logic [1:0] pciAccess_t;

  // Order in which the board functions answer autoconfig
  typedef enum logic [1:0] {cfgIde, cfgBridge, cfgPro, cfgDone} configState_t;

endpackage

//--- source/busCapture.sv
////////////////////////////////////////////////////////////
// Latches one bus cycle's attributes on the start strobe
// and flags the cycle as open until the end strobe
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module busCapture import busDecodePkg::*; (
  input  logic          CLK40,
  input  logic          RESETn,
  input  logic          cycleStart,
  input  logic          cycleEnd,
  input  addrHigh_t     addr,
  input  transferType_t tt,
  input  transferMod_t  tm,
  input  logic          rnw,
  input  busByte_t      dataHigh,
  output addrHigh_t     capAddr,
  output transferType_t capTt,
  output transferMod_t  capTm,
  output logic          capRnw,
  output busByte_t      capData,
  output logic          cycleValid
);

  // Address phase attributes, held for the whole cycle
  always_ff @(posedge CLK40) begin
    if (cycleStart) begin
      capAddr <= addr;
      capTt   <= tt;
      capTm   <= tm;
      capRnw  <= rnw;
      capData <= dataHigh;
    end
  end

  // Open from the start edge up to the edge that sees cycleEnd
  always_ff @(posedge CLK40) begin
    if (!RESETn) begin
      cycleValid <= 1'b0;
    end else if (cycleStart) begin
      cycleValid <= 1'b1;
    end else if (cycleEnd) begin
      cycleValid <= 1'b0;
    end
  end

  // The bus never overlaps two cycles
  assert property (@(posedge CLK40) disable iff (!RESETn) cycleStart |-> !cycleValid)
    else $error("cycleStart while a bus cycle is still open");

endmodule

//--- source/autoconfigBases.sv
////////////////////////////////////////////////////////////
// Autoconfig chain of the board, IDE then bridge then Prometheus
// Each base write in autoconfig space places one function
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "busDecode_settings.svh"

module autoconfigBases import busDecodePkg::*; (
  input  logic        CLK40,
  input  logic        RESETn,
  input  logic        cycleValid,
  input  logic        capRnw,
  input  addrHigh_t   capAddr,
  input  busByte_t    capData,
  input  logic        acWrite,
  output ideBase_t    ideBase,
  output bridgeBase_t bridgeBase,
  output proBase_t    proBase,
  output logic        configured
);

  configState_t state;
  logic         validQ;
  logic         firstEdge;
  logic         baseWrite;

  // Only the first edge of a cycle may step the chain
  always_ff @(posedge CLK40) begin
    if (!RESETn) begin
      validQ <= 1'b0;
    end else begin
      validQ <= cycleValid;
    end
  end

  assign firstEdge = cycleValid && !validQ;

  // Write to the base register, A15:12 == 4
  assign baseWrite = acWrite && !capRnw && firstEdge &&
                     capAddr[3:0] == `AC_REG_BASE;

  ////////////////////////////////////////////////////////////
  // Chain FSM
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK40) begin
    if (!RESETn) begin
      state      <= cfgIde;
      ideBase    <= '0;
      bridgeBase <= '0;
      proBase    <= '0;
    end else if (baseWrite) begin
      case (state)
        cfgIde: begin
          // 128 KB board, D31:25
          ideBase <= capData[7:1];
          state   <= cfgBridge;
        end
        cfgBridge: begin
          // 64 KB board, whole byte
          bridgeBase <= capData;
          state      <= cfgPro;
        end
        cfgPro: begin
          // Z3 board, D31:28 only
          proBase <= capData[7:4];
          state   <= cfgDone;
        end
        default: state <= cfgDone;
      endcase
    end
  end

  assign configured = state == cfgDone;

  // Only a reset restarts the chain
  assert property (@(posedge CLK40) disable iff (!RESETn)
                   state == cfgDone |=> state == cfgDone)
    else $error("autoconfig chain left cfgDone without reset");

endmodule

//--- source/addressDecode.sv
////////////////////////////////////////////////////////////
// Space decode of the captured cycle against the fixed Z2 map
// and the autoconfig bases, plus the sticky ATA enable
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "busDecode_settings.svh"

module addressDecode import busDecodePkg::*; (
  input  logic          CLK40,
  input  logic          RESETn,
  input  logic          ovl,
  input  logic          cycleValid,
  input  logic          capRnw,
  input  logic          configured,
  input  addrHigh_t     capAddr,
  input  transferType_t capTt,
  input  transferMod_t  capTm,
  input  ideBase_t      ideBase,
  input  bridgeBase_t   bridgeBase,
  input  proBase_t      proBase,
  output logic          romSel,
  output logic          ciaSel,
  output logic          ramSel,
  output logic          regSel,
  output logic          rtcSel,
  output logic          autoconfigSel,
  output logic          autovectorSel,
  output logic          ataSel,
  output logic          ataEnable,
  output logic          ataPri0,
  output logic          ataPri1,
  output logic          ataSec0,
  output logic          ataSec1,
  output logic          bridgeRegSel,
  output logic          bridgeProSel,
  output logic          flashSel,
  output flashBank_t    flashBank,
  output pciAccess_t    pciAccess
);

  // capAddr[n] is address bit n+12
  logic [7:0] spaceByte;
  logic [4:0] zone;
  logic       z2;
  logic       cs0;
  logic       cs1;
  logic       altSpace;
  logic       conf0;
  logic       conf1;
  logic       proConf0;
  logic       proConf1;
  logic       proIo;

  assign spaceByte = capAddr[11:4];  // A23:16
  assign zone      = capAddr[11:7];  // A23:19, 512 KB blocks

  // Lower 16 MB only
  assign z2 = cycleValid && capAddr[19:12] == 8'h00;

  ////////////////////////////////////////////////////////////
  // Fixed Z2 spaces
  ////////////////////////////////////////////////////////////

  // Reset vector in low ROM while overlaid, F8-FF always
  assign romSel = z2 && ((zone == 5'b00000 && ovl) || zone == 5'b11111);

  // Chip RAM 00-1F once overlay is off
  assign ramSel = z2 && !ovl && capAddr[11:9] == 3'b000;

  assign ciaSel        = z2 && spaceByte == `SPACE_CIA;
  assign regSel        = z2 && spaceByte == `SPACE_REGS;
  assign rtcSel        = z2 && spaceByte == `SPACE_RTC;
  assign autoconfigSel = z2 && spaceByte == `SPACE_AUTOCONFIG;

  // Interrupt acknowledge, always autovectored
  assign autovectorSel = cycleValid && capTt == 2'b11 && capAddr[19:4] == 16'hFFFF;

  ////////////////////////////////////////////////////////////
  // ATA
  ////////////////////////////////////////////////////////////

  assign ataSel = z2 && configured && capAddr[11:5] == ideBase;

  // Register blocks at A16:12 offsets 1 and 2, A14 picks the drive pair
  assign cs0 = !capAddr[4] && !capAddr[3] && !capAddr[1] && capAddr[0];
  assign cs1 = !capAddr[4] && !capAddr[3] && capAddr[1] && !capAddr[0];

  assign ataPri0 = ataSel && !capAddr[2] && cs0;
  assign ataPri1 = ataSel && capAddr[2] && cs0;
  assign ataSec0 = ataSel && !capAddr[2] && cs1;
  assign ataSec1 = ataSel && capAddr[2] && cs1;

  // Board boots from its own ROM until the first ATA write
  always_ff @(posedge CLK40) begin
    if (!RESETn) begin
      ataEnable <= 1'b0;
    end else if (ataSel && !capRnw) begin
      ataEnable <= 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // PCI bridge windows
  ////////////////////////////////////////////////////////////

  assign bridgeRegSel = z2 && configured && spaceByte == bridgeBase;
  assign bridgeProSel = cycleValid && configured && capAddr[19:16] == proBase;

  // Alternate space cycles carry the config type in TM
  assign altSpace = capTt == 2'b10;
  assign conf0    = altSpace && capTm == 3'd0;
  assign conf1    = altSpace && capTm == 3'd3;

  // Top megabytes of the Prometheus window, A27:20
  assign proConf0 = bridgeProSel && capAddr[15:8] == `PRO_CONF0;
  assign proConf1 = bridgeProSel && capAddr[15:8] == `PRO_CONF1;
  assign proIo    = bridgeProSel && capAddr[15:8] == `PRO_IO;

  // 0 config 0, 1 config 1, 2 memory, 3 I/O
  always_comb begin
    if (proIo) begin
      pciAccess = 2'd3;
    end else if (proConf0 || conf0) begin
      pciAccess = 2'd0;
    end else if (proConf1 || conf1) begin
      pciAccess = 2'd1;
    end else begin
      pciAccess = 2'd2;
    end
  end

  ////////////////////////////////////////////////////////////
  // Flash, four 512 KB banks
  ////////////////////////////////////////////////////////////

  // A8-AF, B0-B7, E0-E7, F0-F7
  assign flashSel = z2 && (zone == 5'b10101 || zone == 5'b10110 ||
                           zone == 5'b11100 || zone == 5'b11110);

  // Bank from A22 and A20
  assign flashBank = {capAddr[10], capAddr[8]};

endmodule

//--- source/selectOutput.sv
////////////////////////////////////////////////////////////
// Registers the decoded selects once per cycle and holds them
// until the cycle closes, then forms the board's select pins
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module selectOutput import busDecodePkg::*; (
  input  logic       CLK40,
  input  logic       RESETn,
  input  logic       cycleValid,
  input  logic       ciaEnable,
  input  addrHigh_t  capAddr,
  input  logic       romSel,
  input  logic       ciaSel,
  input  logic       ramSel,
  input  logic       regSel,
  input  logic       rtcSel,
  input  logic       autoconfigSel,
  input  logic       autovectorSel,
  input  logic       ataSel,
  input  logic       ataEnable,
  input  logic       ataPri0,
  input  logic       ataPri1,
  input  logic       ataSec0,
  input  logic       ataSec1,
  input  logic       bridgeRegSel,
  input  logic       bridgeProSel,
  input  logic       flashSel,
  input  flashBank_t flashBank,
  input  pciAccess_t pciAccess,
  output logic       romSpace,
  output logic       ciaSpace,
  output logic       ciaCs0n,
  output logic       ciaCs1n,
  output logic       ramSpacen,
  output logic       regSpacen,
  output logic       agnusSpace,
  output logic       rtcSpace,
  output logic       autoconfigSpace,
  output logic       autovector,
  output logic       ataSpace,
  output logic       ataEnn,
  output logic       pcs0,
  output logic       pcs1,
  output logic       scs0,
  output logic       scs1,
  output logic       bregEnn,
  output logic       bproEnn,
  output logic       pciSpace,
  output logic       flashSpace,
  output flashBank_t flashBankOut,
  output pciAccess_t pciAccessOut
);

  logic validQ;
  logic ramQ;
  logic regQ;
  logic bregQ;
  logic bproQ;

  // Load on the first edge after capture, hold, clear when the cycle closes
  always_ff @(posedge CLK40) begin
    if (!RESETn || !cycleValid) begin
      validQ          <= 1'b0;
      romSpace        <= 1'b0;
      ciaSpace        <= 1'b0;
      ramQ            <= 1'b0;
      regQ            <= 1'b0;
      rtcSpace        <= 1'b0;
      autoconfigSpace <= 1'b0;
      autovector      <= 1'b0;
      ataSpace        <= 1'b0;
      pcs0            <= 1'b0;
      pcs1            <= 1'b0;
      scs0            <= 1'b0;
      scs1            <= 1'b0;
      bregQ           <= 1'b0;
      bproQ           <= 1'b0;
      flashSpace      <= 1'b0;
      flashBankOut    <= '0;
      pciAccessOut    <= '0;
    end else if (!validQ) begin
      validQ          <= 1'b1;
      romSpace        <= romSel;
      ciaSpace        <= ciaSel;
      ramQ            <= ramSel;
      regQ            <= regSel;
      rtcSpace        <= rtcSel;
      autoconfigSpace <= autoconfigSel;
      autovector      <= autovectorSel;
      ataSpace        <= ataSel;
      pcs0            <= ataPri0;
      pcs1            <= ataPri1;
      scs0            <= ataSec0;
      scs1            <= ataSec1;
      bregQ           <= bridgeRegSel;
      bproQ           <= bridgeProSel;
      flashSpace      <= flashSel;
      flashBankOut    <= flashBank;
      pciAccessOut    <= pciAccess;
    end
  end

  // Agnus owns chip RAM and the chipset registers
  assign ramSpacen  = !ramQ;
  assign regSpacen  = !regQ;
  assign agnusSpace = ramQ || regQ;

  assign bregEnn  = !bregQ;
  assign bproEnn  = !bproQ;
  assign pciSpace = bregQ || bproQ;

  // IDE ROM answers until the latch flips
  assign ataEnn = !(ataSpace && ataEnable);

  // CIA A on A12 low, CIA B on A13 low, paced by the E clock enable
  assign ciaCs0n = !(ciaSpace && ciaEnable && !capAddr[0]);
  assign ciaCs1n = !(ciaSpace && ciaEnable && !capAddr[1]);

  // Fixed Z2 spaces never overlap
  assert property (@(posedge CLK40) disable iff (!RESETn)
                   $onehot0({romSpace, ciaSpace, ramQ, regQ, rtcSpace,
                             autoconfigSpace, flashSpace}))
    else $error("more than one primary Z2 space selected");

endmodule

//--- source/busDecodeTop.sv
////////////////////////////////////////////////////////////
// Bus decoder of the accelerator board
// Capture, autoconfig chain, space decode and select registers
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module busDecodeTop import busDecodePkg::*; (
  input  logic          CLK40,
  input  logic          RESETn,
  input  logic          cycleStart,
  input  addrHigh_t     addr,
  input  transferType_t tt,
  input  transferMod_t  tm,
  input  logic          rnw,
  input  busByte_t      dataHigh,
  input  logic          cycleEnd,
  input  logic          ovl,
  input  logic          ciaEnable,
  output logic          romSpace,
  output logic          ciaSpace,
  output logic          ciaCs0n,
  output logic          ciaCs1n,
  output logic          ramSpacen,
  output logic          regSpacen,
  output logic          agnusSpace,
  output logic          rtcSpace,
  output logic          autoconfigSpace,
  output logic          autovector,
  output logic          ataSpace,
  output logic          ataEnn,
  output logic          pcs0,
  output logic          pcs1,
  output logic          scs0,
  output logic          scs1,
  output logic          bregEnn,
  output logic          bproEnn,
  output logic          pciSpace,
  output logic          flashSpace,
  output flashBank_t    flashBankOut,
  output pciAccess_t    pciAccessOut
);

  // Captured cycle
  addrHigh_t     capAddr;
  transferType_t capTt;
  transferMod_t  capTm;
  logic          capRnw;
  busByte_t      capData;
  logic          cycleValid;

  // Autoconfig results
  ideBase_t    ideBase;
  bridgeBase_t bridgeBase;
  proBase_t    proBase;
  logic        configured;

  // Raw selects
  logic       romSel;
  logic       ciaSel;
  logic       ramSel;
  logic       regSel;
  logic       rtcSel;
  logic       autoconfigSel;
  logic       autovectorSel;
  logic       ataSel;
  logic       ataEnable;
  logic       ataPri0;
  logic       ataPri1;
  logic       ataSec0;
  logic       ataSec1;
  logic       bridgeRegSel;
  logic       bridgeProSel;
  logic       flashSel;
  flashBank_t flashBank;
  pciAccess_t pciAccess;

  busCapture capture (
    .CLK40      (CLK40),
    .RESETn     (RESETn),
    .cycleStart (cycleStart),
    .cycleEnd   (cycleEnd),
    .addr       (addr),
    .tt         (tt),
    .tm         (tm),
    .rnw        (rnw),
    .dataHigh   (dataHigh),
    .capAddr    (capAddr),
    .capTt      (capTt),
    .capTm      (capTm),
    .capRnw     (capRnw),
    .capData    (capData),
    .cycleValid (cycleValid)
  );

  // Base writes come from the raw autoconfig select
  autoconfigBases autoconfig (
    .CLK40      (CLK40),
    .RESETn     (RESETn),
    .cycleValid (cycleValid),
    .capRnw     (capRnw),
    .capAddr    (capAddr),
    .capData    (capData),
    .acWrite    (autoconfigSel),
    .ideBase    (ideBase),
    .bridgeBase (bridgeBase),
    .proBase    (proBase),
    .configured (configured)
  );

  addressDecode decode (
    .CLK40         (CLK40),
    .RESETn        (RESETn),
    .ovl           (ovl),
    .cycleValid    (cycleValid),
    .capRnw        (capRnw),
    .configured    (configured),
    .capAddr       (capAddr),
    .capTt         (capTt),
    .capTm         (capTm),
    .ideBase       (ideBase),
    .bridgeBase    (bridgeBase),
    .proBase       (proBase),
    .romSel        (romSel),
    .ciaSel        (ciaSel),
    .ramSel        (ramSel),
    .regSel        (regSel),
    .rtcSel        (rtcSel),
    .autoconfigSel (autoconfigSel),
    .autovectorSel (autovectorSel),
    .ataSel        (ataSel),
    .ataEnable     (ataEnable),
    .ataPri0       (ataPri0),
    .ataPri1       (ataPri1),
    .ataSec0       (ataSec0),
    .ataSec1       (ataSec1),
    .bridgeRegSel  (bridgeRegSel),
    .bridgeProSel  (bridgeProSel),
    .flashSel      (flashSel),
    .flashBank     (flashBank),
    .pciAccess     (pciAccess)
  );

  selectOutput outputs (
    .CLK40           (CLK40),
    .RESETn          (RESETn),
    .cycleValid      (cycleValid),
    .ciaEnable       (ciaEnable),
    .capAddr         (capAddr),
    .romSel          (romSel),
    .ciaSel          (ciaSel),
    .ramSel          (ramSel),
    .regSel          (regSel),
    .rtcSel          (rtcSel),
    .autoconfigSel   (autoconfigSel),
    .autovectorSel   (autovectorSel),
    .ataSel          (ataSel),
    .ataEnable       (ataEnable),
    .ataPri0         (ataPri0),
    .ataPri1         (ataPri1),
    .ataSec0         (ataSec0),
    .ataSec1         (ataSec1),
    .bridgeRegSel    (bridgeRegSel),
    .bridgeProSel    (bridgeProSel),
    .flashSel        (flashSel),
    .flashBank       (flashBank),
    .pciAccess       (pciAccess),
    .romSpace        (romSpace),
    .ciaSpace        (ciaSpace),
    .ciaCs0n         (ciaCs0n),
    .ciaCs1n         (ciaCs1n),
    .ramSpacen       (ramSpacen),
    .regSpacen       (regSpacen),
    .agnusSpace      (agnusSpace),
    .rtcSpace        (rtcSpace),
    .autoconfigSpace (autoconfigSpace),
    .autovector      (autovector),
    .ataSpace        (ataSpace),
    .ataEnn          (ataEnn),
    .pcs0            (pcs0),
    .pcs1            (pcs1),
    .scs0            (scs0),
    .scs1            (scs1),
    .bregEnn         (bregEnn),
    .bproEnn         (bproEnn),
    .pciSpace        (pciSpace),
    .flashSpace      (flashSpace),
    .flashBankOut    (flashBankOut),
    .pciAccessOut    (pciAccessOut)
  );

endmodule

//--- test/busDecodeTb.sv
////////////////////////////////////////////////////////////
// Testbench of the bus decoder, one bus cycle per test step
// Reference model predicts every select, a compare process checks
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "busDecode_settings.svh"

module busDecodeTb import busDecodePkg::*; ();

  localparam int cycleLimit = 20;

  // Output vector with no cycle open
  localparam logic [23:0] idleOut = {12'b0011_1100_0001, 4'b0000, 4'b1100, 2'b00, 2'b00};

  logic          CLK40;
  logic          RESETn;
  logic          cycleStart;
  addrHigh_t     addr;
  transferType_t tt;
  transferMod_t  tm;
  logic          rnw;
  busByte_t      dataHigh;
  logic          cycleEnd;
  logic          ovl;
  logic          ciaEnable;
  logic          romSpace;
  logic          ciaSpace;
  logic          ciaCs0n;
  logic          ciaCs1n;
  logic          ramSpacen;
  logic          regSpacen;
  logic          agnusSpace;
  logic          rtcSpace;
  logic          autoconfigSpace;
  logic          autovector;
  logic          ataSpace;
  logic          ataEnn;
  logic          pcs0;
  logic          pcs1;
  logic          scs0;
  logic          scs1;
  logic          bregEnn;
  logic          bproEnn;
  logic          pciSpace;
  logic          flashSpace;
  flashBank_t    flashBankOut;
  pciAccess_t    pciAccessOut;

  // Compare request from stimulus to the compare process
  logic [23:0] actualOut;
  logic [23:0] expectedOut;
  string       checkName;
  int          checkRequest = 0;
  int          checkServed = 0;

  // Model copy of the autoconfig chain and the ATA latch
  logic [6:0]  modelIde;
  logic [7:0]  modelBridge;
  logic [3:0]  modelPro;
  logic        modelCfg;
  logic        modelAtaEn;
  int          modelStep;

  logic [31:0] rng;

  busDecodeTop UUT (.*);

  assign actualOut = {romSpace, ciaSpace, ciaCs0n, ciaCs1n, ramSpacen, regSpacen, agnusSpace,
                      rtcSpace, autoconfigSpace, autovector, ataSpace, ataEnn,
                      pcs0, pcs1, scs0, scs1, bregEnn, bproEnn, pciSpace, flashSpace,
                      flashBankOut, pciAccessOut};

  initial begin
    CLK40 = 1'b0;
    forever #50 CLK40 = ~CLK40;
  end

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] s;
    s = x ^ (x << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  // Inputs change 5 ns after the rising edge
  task automatic tick();
    @(posedge CLK40);
    #5;
  endtask

  task automatic checkValue(input string name, input logic [23:0] expected,
                            input logic [23:0] actual);
    if (actual !== expected) begin
      $display("ERROR %s: expected %h, actual %h", name, expected, actual);
      $display("test failed");
      $fatal(1, "compare mismatch");
    end
  endtask

  task automatic waitCycleValid(input logic level, input string name);
    int n;
    n = 0;
    while (UUT.cycleValid !== level && n < cycleLimit) begin
      tick();
      n++;
    end
    if (UUT.cycleValid !== level) begin
      $display("timeout in %s: bus cycle flag never went to %b", name, level);
      $display("test failed");
      $fatal(1, "timeout");
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////

  // Full 32 bit address, same bit order as the output vector
  function automatic logic [23:0] decodeModel(
    input logic [31:0] a, input logic [1:0] t, input logic [2:0] m, input logic r,
    input logic ovlIn, input logic ciaIn, input logic [6:0] ideB,
    input logic [7:0] bridgeB, input logic [3:0] proB, input logic cfg, input logic ataEn);
    logic       z2;
    logic       rom;
    logic       ram;
    logic       cia;
    logic       regs;
    logic       rtc;
    logic       ac;
    logic       av;
    logic       ata;
    logic       breg;
    logic       bpro;
    logic       flash;
    logic [4:0] block;
    logic [3:0] dev;
    logic [1:0] access;
    z2    = a[31:24] == 8'h00;
    block = a[23:19];
    rom   = z2 && ((ovlIn && block == 5'h00) || block == 5'h1F);
    ram   = z2 && !ovlIn && a[23:21] == 3'b000;
    cia   = z2 && a[23:16] == `SPACE_CIA;
    regs  = z2 && a[23:16] == `SPACE_REGS;
    rtc   = z2 && a[23:16] == `SPACE_RTC;
    ac    = z2 && a[23:16] == `SPACE_AUTOCONFIG;
    av    = t == 2'd3 && a[31:16] == 16'hFFFF;
    ata   = z2 && cfg && a[23:17] == ideB;
    // Order pcs0 pcs1 scs0 scs1
    dev = 4'b0000;
    if (ata) begin
      case (a[16:12])
        5'b00001: dev = 4'b1000;
        5'b00101: dev = 4'b0100;
        5'b00010: dev = 4'b0010;
        5'b00110: dev = 4'b0001;
        default:  dev = 4'b0000;
      endcase
    end
    breg  = z2 && cfg && a[23:16] == bridgeB;
    bpro  = cfg && a[31:28] == proB;
    flash = z2 && (block == 5'b10101 || block == 5'b10110 ||
                   block == 5'b11100 || block == 5'b11110);
    access = 2'd2;
    if (bpro && a[27:20] == `PRO_IO) begin
      access = 2'd3;
    end else if ((bpro && a[27:20] == `PRO_CONF0) || (t == 2'd2 && m == 3'd0)) begin
      access = 2'd0;
    end else if ((bpro && a[27:20] == `PRO_CONF1) || (t == 2'd2 && m == 3'd3)) begin
      access = 2'd1;
    end
    // A write to ATA space already enables the drive in its own cycle
    return {rom, cia, !(cia && ciaIn && !a[12]), !(cia && ciaIn && !a[13]),
            !ram, !regs, ram || regs, rtc, ac, av, ata, !(ata && (ataEn || !r)),
            dev, !breg, !bpro, breg || bpro, flash, {a[22], a[20]}, access};
  endfunction

  // State changes that a finished cycle leaves behind
  task automatic updateModel(input logic [31:0] a, input logic r, input logic [7:0] d);
    logic z2;
    z2 = a[31:24] == 8'h00;
    if (z2 && modelCfg && a[23:17] == modelIde && !r) begin
      modelAtaEn = 1'b1;
    end
    if (z2 && a[23:16] == `SPACE_AUTOCONFIG && a[15:12] == `AC_REG_BASE && !r &&
        modelStep < 3) begin
      case (modelStep)
        0:       modelIde = d[7:1];
        1:       modelBridge = d;
        default: modelPro = d[7:4];
      endcase
      modelStep = modelStep + 1;
      modelCfg = modelStep == 3;
    end
  endtask

  // One bus cycle, checked after the select edge and again once closed
  task automatic runCycle(input string name, input logic [31:0] a, input logic [1:0] t,
                          input logic [2:0] m, input logic r, input logic [7:0] d,
                          input logic cia);
    addr       = a[31:12];
    tt         = t;
    tm         = m;
    rnw        = r;
    dataHigh   = d;
    ciaEnable  = cia;
    cycleStart = 1'b1;
    tick();
    cycleStart = 1'b0;
    waitCycleValid(1'b1, name);
    tick();
    checkName   = name;
    expectedOut = decodeModel(a, t, m, r, ovl, cia, modelIde, modelBridge, modelPro,
                              modelCfg, modelAtaEn);
    checkRequest = checkRequest + 1;
    tick();
    // CIA chip selects track the enable level inside a held cycle
    ciaEnable    = !cia;
    checkName    = {name, " cia enable"};
    expectedOut  = decodeModel(a, t, m, r, ovl, !cia, modelIde, modelBridge, modelPro,
                               modelCfg, modelAtaEn);
    checkRequest = checkRequest + 1;
    updateModel(a, r, d);
    cycleEnd = 1'b1;
    tick();
    cycleEnd = 1'b0;
    waitCycleValid(1'b0, name);
    tick();
    checkName    = {name, " clear"};
    expectedOut  = idleOut;
    checkRequest = checkRequest + 1;
    tick();
  endtask

  // Mid low phase, every output settled
  always @(negedge CLK40) begin
    if (checkServed != checkRequest) begin
      checkValue(checkName, expectedOut, actualOut);
      checkServed = checkServed + 1;
    end
  end

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  initial begin
    logic [31:0] a;
    logic [7:0]  hi;
    int          i;
    RESETn      = 1'b0;
    cycleStart  = 1'b0;
    cycleEnd    = 1'b0;
    addr        = '0;
    tt          = '0;
    tm          = '0;
    rnw         = 1'b1;
    dataHigh    = '0;
    ovl         = 1'b1;
    ciaEnable   = 1'b0;
    rng         = 32'd52;
    modelIde    = '0;
    modelBridge = '0;
    modelPro    = '0;
    modelCfg    = 1'b0;
    modelAtaEn  = 1'b0;
    modelStep   = 0;
    repeat (3) @(posedge CLK40);
    #5;
    RESETn = 1'b1;
    tick();

    // Reset and overlay
    checkName    = "reset";
    expectedOut  = idleOut;
    checkRequest = checkRequest + 1;
    checkValue("reset configured", 24'd0, {23'd0, UUT.configured});
    tick();
    runCycle("overlay rom", 32'h0000_0000, 2'd0, 3'd0, 1'b1, 8'h00, 1'b0);
    runCycle("overlay high rom", 32'h00F8_0000, 2'd0, 3'd0, 1'b1, 8'h00, 1'b0);
    ovl = 1'b0;
    runCycle("chip ram", 32'h0000_0000, 2'd0, 3'd0, 1'b1, 8'h00, 1'b0);
    runCycle("high rom", 32'h00F8_0000, 2'd0, 3'd0, 1'b1, 8'h00, 1'b0);

    // CIA A and CIA B, gated and ungated
    runCycle("cia a gated", 32'h00BF_E001, 2'd0, 3'd0, 1'b1, 8'h00, 1'b0);
    runCycle("cia a", 32'h00BF_E001, 2'd0, 3'd0, 1'b1, 8'h00, 1'b1);
    runCycle("cia b", 32'h00BF_D000, 2'd0, 3'd0, 1'b1, 8'h00, 1'b1);

    // Fixed spaces and flash banks, reads only so the chain stays put
    for (i = 0; i < 200; i++) begin
      rng = xorshift(rng);
      case (rng[2:0])
        3'd0:    hi = `SPACE_CIA;
        3'd1:    hi = `SPACE_REGS;
        3'd2:    hi = `SPACE_RTC;
        3'd3:    hi = `SPACE_AUTOCONFIG;
        3'd4:    hi = {5'b10101, rng[5:3]};
        3'd5:    hi = {5'b10110, rng[5:3]};
        3'd6:    hi = {5'b11100, rng[5:3]};
        default: hi = {5'b11110, rng[5:3]};
      endcase
      a = {8'h00, hi, rng[31:16]};
      runCycle("fixed space random", a, 2'd0, rng[8:6], 1'b1, rng[15:8], rng[9]);
    end

    // Windows stay dark until the chain is done
    // Reset bases all decode at address zero
    runCycle("ata before config", 32'h0000_1000, 2'd0, 3'd0, 1'b1, 8'h00, 1'b0);
    runCycle("bridge before config", 32'h0000_2000, 2'd0, 3'd0, 1'b1, 8'h00, 1'b0);
    runCycle("pro before config", 32'h0FC0_0000, 2'd0, 3'd0, 1'b1, 8'h00, 1'b0);

    // IDE at EA, bridge at EC, Prometheus at 4000 0000
    runCycle("autoconfig ide", 32'h00E8_4000, 2'd0, 3'd0, 1'b0, 8'hEA, 1'b0);
    // Placed bases still dark while the chain runs
    runCycle("ata mid config", 32'h00EA_1000, 2'd0, 3'd0, 1'b1, 8'h00, 1'b0);
    runCycle("autoconfig bridge", 32'h00E8_4000, 2'd0, 3'd0, 1'b0, 8'hEC, 1'b0);
    runCycle("bridge mid config", 32'h00EC_0000, 2'd0, 3'd0, 1'b1, 8'h00, 1'b0);
    runCycle("autoconfig prometheus", 32'h00E8_4000, 2'd0, 3'd0, 1'b0, 8'h40, 1'b0);
    checkValue("configured", 24'd1, {23'd0, UUT.configured});

    for (i = 0; i < 60; i++) begin
      rng = xorshift(rng);
      case (rng[1:0])
        2'd0:    a = {8'h00, 7'h75, rng[16:0]};
        2'd1:    a = {8'h00, 8'hEC, rng[31:16]};
        2'd2:    a = {4'h4, rng[31:4]};
        default: a = {8'h00, rng[31:8]};
      endcase
      runCycle("configured window random", a, 2'd0, 3'd0, 1'b1, 8'h00, 1'b0);
    end

    // ATA drive selects, then the enable latch
    runCycle("ata pcs0", 32'h00EA_1000, 2'd0, 3'd0, 1'b1, 8'h00, 1'b0);
    runCycle("ata pcs1", 32'h00EA_5000, 2'd0, 3'd0, 1'b1, 8'h00, 1'b0);
    runCycle("ata scs0", 32'h00EA_2000, 2'd0, 3'd0, 1'b1, 8'h00, 1'b0);
    runCycle("ata scs1", 32'h00EA_6000, 2'd0, 3'd0, 1'b1, 8'h00, 1'b0);
    runCycle("ata no device", 32'h00EB_0000, 2'd0, 3'd0, 1'b1, 8'h00, 1'b0);
    runCycle("ata first write", 32'h00EA_1000, 2'd0, 3'd0, 1'b0, 8'h5A, 1'b0);
    runCycle("ata enabled read", 32'h00EA_6000, 2'd0, 3'd0, 1'b1, 8'h00, 1'b0);
    runCycle("ata enabled base", 32'h00EA_0000, 2'd0, 3'd0, 1'b1, 8'h00, 1'b0);

    // PCI access type
    runCycle("pci config 0", 32'h4FC0_0000, 2'd0, 3'd0, 1'b1, 8'h00, 1'b0);
    runCycle("pci config 1", 32'h4FD0_0000, 2'd0, 3'd0, 1'b1, 8'h00, 1'b0);
    runCycle("pci io", 32'h4FE0_1000, 2'd0, 3'd0, 1'b1, 8'h00, 1'b0);
    runCycle("pci memory", 32'h4100_0000, 2'd0, 3'd0, 1'b1, 8'h00, 1'b0);
    runCycle("alt space tm 0", 32'h00C0_0000, 2'd2, 3'd0, 1'b1, 8'h00, 1'b0);
    runCycle("alt space tm 3", 32'h00C0_0000, 2'd2, 3'd3, 1'b1, 8'h00, 1'b0);
    runCycle("autovector", 32'hFFFF_F000, 2'd3, 3'd5, 1'b1, 8'h00, 1'b0);

    tick();
    if (checkServed == checkRequest && checkServed > 0) begin
      $display("test passed");
      $finish;
    end else begin
      $display("compare process did not finish all requested checks");
      $display("test failed");
      $fatal(1, "checks missing");
    end
  end

endmodule

//--- vlog.f
+incdir+include
source/busDecodePkg.sv
source/busCapture.sv
source/autoconfigBases.sv
source/addressDecode.sv
source/selectOutput.sv
source/busDecodeTop.sv
test/busDecodeTb.sv

//--- Makefile
# Verilator build of the bus decoder testbench

VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = busDecodeTb
FILELIST  = vlog.f
OBJDIR    = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

# The simulator status is not trusted, the log decides
run: compile
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "^test passed$$" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
